// File: Makefile
# Verilator build and run of the DMA channel register testbench.
TOP = dma_chn_regs_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) --Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir

// File: compile.f
+incdir+hdl
hdl/dma_chn_pkg.sv
hdl/dma_chn_ahb_slv.sv
hdl/dma_chn_cfg_regs.sv
hdl/dma_chn_int_ctrl.sv
hdl/dma_chn_regs.sv
dv/dma_chn_regs_props.sv
dv/dma_chn_regs_tb.sv

// File: dv/dma_chn_regs_props.sv
// ####################
// Concurrent checks on the channel register block, bound to its top level.
// ####################
`timescale 1ns/1ps
`default_nettype none

module dma_chn_regs_props (
  input logic               hclk,
  input logic               hrst_n,
  input logic               chn_en,
  input logic               chn_soft_trg,
  input logic               chn_irq,
  input logic               int_en,
  input logic               wr_stb,
  input logic               ev_err,
  input logic               ev_htfr,
  input logic               ev_tfr,
  input logic               ev_trgcmp,
  input logic               ev_pend,
  input dma_chn_pkg::data_t chn_sar
);

  // software trigger is a single cycle pulse.
  a_soft_trg_single: assert property (
    @(posedge hclk) disable iff (!hrst_n) chn_soft_trg |=> !chn_soft_trg
  ) else $error("chn_soft_trg high for two cycles in a row");

  // irq only rises with int_en set, after an event or a register write.
  a_irq_rise_cause: assert property (
    @(posedge hclk) disable iff (!hrst_n)
      $rose(chn_irq) |-> int_en &&
        $past(ev_err || ev_htfr || ev_tfr || ev_trgcmp || ev_pend || wr_stb)
  ) else $error("chn_irq rose without int_en or without an event or register write");

  a_sar_locked: assert property (
    @(posedge hclk) disable iff (!hrst_n) chn_en |=> $stable(chn_sar)
  ) else $error("chn_sar changed while the channel was enabled"); // config lock.

endmodule

bind dma_chn_regs dma_chn_regs_props u_props (
  .hclk         (hclk),
  .hrst_n       (hrst_n),
  .chn_en       (chn_en),
  .chn_soft_trg (chn_soft_trg),
  .chn_irq      (chn_irq),
  .int_en       (int_en),
  .wr_stb       (wr_stb),
  .ev_err       (ev_err),
  .ev_htfr      (ev_htfr),
  .ev_tfr       (ev_tfr),
  .ev_trgcmp    (ev_trgcmp),
  .ev_pend      (ev_pend),
  .chn_sar      (chn_sar)
);

`default_nettype wire

// File: dv/dma_chn_regs_tb.sv
// ####################
// Testbench of the DMA channel register block. Applies a table of bus,
// event and idle entries and checks read data and channel outputs.
// ####################
`timescale 1ns/1ps
`default_nettype none

`include "dma_chn_config.svh"

module dma_chn_regs_tb;

  typedef enum {K_WRITE, K_READ, K_EVENT, K_IDLE} kind_e;
  typedef enum {OUT_NONE, OUT_RDATA, OUT_SAR, OUT_DAR, OUT_CTRL, OUT_TRG, OUT_FLAGS} out_e;

  localparam logic [`DMA_ADDR_W-1:0] A_SAR    = `DMA_ADDR_W'(`DMA_CHN_BASE + `DMA_SAR_OFS);
  localparam logic [`DMA_ADDR_W-1:0] A_DAR    = `DMA_ADDR_W'(`DMA_CHN_BASE + `DMA_DAR_OFS);
  localparam logic [`DMA_ADDR_W-1:0] A_CTRL_A = `DMA_ADDR_W'(`DMA_CHN_BASE + `DMA_CTRL_A_OFS);
  localparam logic [`DMA_ADDR_W-1:0] A_CTRL_B = `DMA_ADDR_W'(`DMA_CHN_BASE + `DMA_CTRL_B_OFS);
  localparam logic [`DMA_ADDR_W-1:0] A_MASK   = `DMA_ADDR_W'(`DMA_CHN_BASE + `DMA_INT_MASK_OFS);
  localparam logic [`DMA_ADDR_W-1:0] A_STATUS = `DMA_ADDR_W'(`DMA_CHN_BASE + `DMA_INT_STATUS_OFS);
  localparam logic [`DMA_ADDR_W-1:0] A_CLEAR  = `DMA_ADDR_W'(`DMA_CHN_BASE + `DMA_INT_CLEAR_OFS);
  localparam logic [`DMA_ADDR_W-1:0] A_SOFT   = `DMA_ADDR_W'(`DMA_CHN_BASE + `DMA_SOFT_REQ_OFS);
  localparam logic [`DMA_ADDR_W-1:0] A_EN     = `DMA_ADDR_W'(`DMA_CHN_BASE + `DMA_EN_OFS);
  localparam dma_chn_pkg::data_t CTRL_A_FIELDS = 32'h00ff_f0ff; // block_tl, inc modes, widths.
  localparam dma_chn_pkg::data_t CTRL_B_FIELDS = 32'h0000_0007;

  logic                       hclk;
  logic                       hrst_n;
  logic                       hsel;
  dma_chn_pkg::htrans_e       htrans;
  logic                       hwrite;
  logic [`DMA_ADDR_W-1:0]     haddr;
  dma_chn_pkg::data_t         hwdata;
  dma_chn_pkg::data_t         hrdata;
  logic                       ev_err;
  logic                       ev_htfr;
  logic                       ev_tfr;
  logic                       ev_trgcmp;
  logic                       ev_pend;
  logic                       en_clr;
  dma_chn_pkg::data_t         chn_sar;
  dma_chn_pkg::data_t         chn_dar;
  dma_chn_pkg::block_tl_t     chn_block_tl;
  dma_chn_pkg::addr_inc_e     chn_sinc;
  dma_chn_pkg::addr_inc_e     chn_dinc;
  dma_chn_pkg::tr_width_e     chn_src_width;
  dma_chn_pkg::tr_width_e     chn_dst_width;
  logic [1:0]                 chn_trg_mode;
  logic                       chn_en;
  logic                       chn_soft_trg;
  logic                       chn_pend;
  logic                       chn_irq;

  // stimulus table, one queue per column.
  string                  t_name[$];
  kind_e                  t_kind[$];
  logic                   t_hsel[$];
  dma_chn_pkg::htrans_e   t_trans[$];
  logic [`DMA_ADDR_W-1:0] t_addr[$];
  dma_chn_pkg::data_t     t_data[$];
  out_e                   t_out[$];
  dma_chn_pkg::data_t     t_exp[$];
  logic                   table_ready;

  dma_chn_regs u_dut (
    .hclk          (hclk),
    .hrst_n        (hrst_n),
    .hsel          (hsel),
    .htrans        (htrans),
    .hwrite        (hwrite),
    .haddr         (haddr),
    .hwdata        (hwdata),
    .hrdata        (hrdata),
    .ev_err        (ev_err),
    .ev_htfr       (ev_htfr),
    .ev_tfr        (ev_tfr),
    .ev_trgcmp     (ev_trgcmp),
    .ev_pend       (ev_pend),
    .en_clr        (en_clr),
    .chn_sar       (chn_sar),
    .chn_dar       (chn_dar),
    .chn_block_tl  (chn_block_tl),
    .chn_sinc      (chn_sinc),
    .chn_dinc      (chn_dinc),
    .chn_src_width (chn_src_width),
    .chn_dst_width (chn_dst_width),
    .chn_trg_mode  (chn_trg_mode),
    .chn_en        (chn_en),
    .chn_soft_trg  (chn_soft_trg),
    .chn_pend      (chn_pend),
    .chn_irq       (chn_irq)
  );

  initial begin
    hclk = 1'b0;
    forever #5 hclk = ~hclk;
  end

  task automatic check_data(input string name, input string what,
                            input dma_chn_pkg::data_t exp, input dma_chn_pkg::data_t act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected 0x%08h, actual 0x%08h", name, what, exp, act);
      $display("TEST FAILED");
      $fatal(1, "data compare mismatch");
    end
  endtask

  task automatic check_bit(input string name, input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected %0b, actual %0b", name, what, exp, act);
      $display("TEST FAILED");
      $fatal(1, "bit compare mismatch");
    end
  endtask

  task automatic check_width(input string name, input string what,
                             input dma_chn_pkg::tr_width_e exp, input dma_chn_pkg::tr_width_e act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected %0d, actual %0d", name, what, exp, act);
      $display("TEST FAILED");
      $fatal(1, "width compare mismatch");
    end
  endtask

  task automatic check_inc(input string name, input string what,
                           input dma_chn_pkg::addr_inc_e exp, input dma_chn_pkg::addr_inc_e act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected %0d, actual %0d", name, what, exp, act);
      $display("TEST FAILED");
      $fatal(1, "increment compare mismatch");
    end
  endtask

  // bit 3 irq, bit 2 pend, bit 1 soft trigger, bit 0 enable.
  function automatic dma_chn_pkg::data_t pack_flags(input logic irq, input logic pend,
                                                    input logic trg, input logic en);
    return {28'h0, irq, pend, trg, en};
  endfunction

  task automatic add_entry(input string name, input kind_e kind, input logic sel_v,
                           input dma_chn_pkg::htrans_e trans, input logic [`DMA_ADDR_W-1:0] addr,
                           input dma_chn_pkg::data_t data, input out_e out,
                           input dma_chn_pkg::data_t exp);
    t_name.push_back(name);
    t_kind.push_back(kind);
    t_hsel.push_back(sel_v);
    t_trans.push_back(trans);
    t_addr.push_back(addr);
    t_data.push_back(data);
    t_out.push_back(out);
    t_exp.push_back(exp);
  endtask

  task automatic add_write(input string name, input logic [`DMA_ADDR_W-1:0] addr,
                           input dma_chn_pkg::data_t data, input out_e out,
                           input dma_chn_pkg::data_t exp);
    add_entry(name, K_WRITE, 1'b1, dma_chn_pkg::NONSEQ, addr, data, out, exp);
  endtask

  task automatic add_read(input string name, input logic [`DMA_ADDR_W-1:0] addr,
                          input dma_chn_pkg::data_t exp);
    add_entry(name, K_READ, 1'b1, dma_chn_pkg::NONSEQ, addr, '0, OUT_RDATA, exp);
  endtask

  // event bits 4:0 as in int_vec_t, bit 5 drives en_clr.
  task automatic add_event(input string name, input dma_chn_pkg::data_t bits,
                           input dma_chn_pkg::data_t exp);
    add_entry(name, K_EVENT, 1'b0, dma_chn_pkg::IDLE, '0, bits, OUT_FLAGS, exp);
  endtask

  task automatic add_idle(input string name, input logic sel_v, input dma_chn_pkg::htrans_e trans,
                          input logic [`DMA_ADDR_W-1:0] addr, input dma_chn_pkg::data_t data,
                          input out_e out, input dma_chn_pkg::data_t exp);
    add_entry(name, K_IDLE, sel_v, trans, addr, data, out, exp);
  endtask

  task automatic build_table();
    dma_chn_pkg::data_t rs;
    dma_chn_pkg::data_t rd;
    dma_chn_pkg::data_t ra;
    dma_chn_pkg::data_t rb;
    dma_chn_pkg::data_t r4;
    rs = $urandom;
    rd = $urandom;
    ra = $urandom;
    rb = $urandom;
    r4 = $urandom;
    add_idle("rst_flags", 1'b0, dma_chn_pkg::IDLE, '0, '0, OUT_FLAGS, pack_flags(0, 0, 0, 0));
    add_idle("rst_ctrl", 1'b0, dma_chn_pkg::IDLE, '0, '0, OUT_CTRL, '0);
    add_read("rst_sar", A_SAR, '0);
    add_read("rst_dar", A_DAR, '0);
    add_read("rst_ctrl_a", A_CTRL_A, '0);
    add_read("rst_ctrl_b", A_CTRL_B, '0);
    add_read("rst_mask", A_MASK, '0);
    add_read("rst_status", A_STATUS, '0);
    add_read("rst_en", A_EN, '0);
    add_write("sar_wr", A_SAR, rs, OUT_SAR, rs);
    add_read("sar_rd", A_SAR, rs);
    add_write("dar_wr", A_DAR, rd, OUT_DAR, rd);
    add_entry("dar_rd_seq", K_READ, 1'b1, dma_chn_pkg::SEQ, A_DAR, '0, OUT_RDATA, rd);
    add_write("ctrl_a_wr", A_CTRL_A, ra, OUT_CTRL, ra & CTRL_A_FIELDS);
    add_read("ctrl_a_rd", A_CTRL_A, ra & CTRL_A_FIELDS);
    add_entry("ctrl_b_wr_seq", K_WRITE, 1'b1, dma_chn_pkg::SEQ, A_CTRL_B, rb, OUT_TRG,
              rb & CTRL_B_FIELDS);
    add_read("ctrl_b_rd", A_CTRL_B, rb & CTRL_B_FIELDS);
    // enabled channel locks its setup.
    add_write("en_set", A_EN, 32'h1, OUT_FLAGS, pack_flags(0, 0, 0, 1));
    add_write("sar_locked", A_SAR, ~rs, OUT_SAR, rs);
    add_write("ctrl_a_locked", A_CTRL_A, ~ra, OUT_CTRL, ra & CTRL_A_FIELDS);
    add_read("sar_locked_rd", A_SAR, rs);
    add_read("en_rd", A_EN, 32'h1);
    add_event("en_clr", 32'h20, pack_flags(0, 0, 0, 0));
    add_write("sar_unlocked", A_SAR, r4, OUT_SAR, r4);
    add_write("int_en_on", A_CTRL_B, 32'h1, OUT_TRG, 32'h1);
    add_write("mask_all", A_MASK, 32'hffff_ffff, OUT_NONE, '0);
    add_read("mask_rd", A_MASK, 32'h1f);
    add_event("ev_err", 32'h01, pack_flags(1, 0, 0, 0));
    add_event("ev_xfer", 32'h0e, pack_flags(1, 0, 0, 0));
    add_read("status_rd", A_STATUS, 32'h0f);
    add_event("ev_pend", 32'h10, pack_flags(1, 1, 0, 0));
    add_read("status_no_pend", A_STATUS, 32'h0f);
    add_write("clear_all", A_CLEAR, 32'h1f, OUT_NONE, '0);
    add_read("status_cleared", A_STATUS, '0);
    add_idle("flags_cleared", 1'b0, dma_chn_pkg::IDLE, '0, '0, OUT_FLAGS, pack_flags(0, 0, 0, 0));
    add_write("mask_pend", A_MASK, 32'h10, OUT_NONE, '0);
    add_event("ev_pend_irq", 32'h10, pack_flags(1, 1, 0, 0));
    add_write("int_en_off", A_CTRL_B, 32'h0, OUT_FLAGS, pack_flags(0, 1, 0, 0));
    add_write("int_en_back", A_CTRL_B, 32'h1, OUT_FLAGS, pack_flags(1, 1, 0, 0));
    add_write("mask_low", A_MASK, 32'h0f, OUT_FLAGS, pack_flags(0, 1, 0, 0));
    add_event("ev_tfr", 32'h02, pack_flags(1, 1, 0, 0));
    add_write("clear_tfr", A_CLEAR, 32'h02, OUT_NONE, '0);
    add_idle("pend_kept", 1'b0, dma_chn_pkg::IDLE, '0, '0, OUT_FLAGS, pack_flags(0, 1, 0, 0));
    add_write("clear_rest", A_CLEAR, 32'hffff_ffff, OUT_NONE, '0);
    add_idle("flags_none", 1'b0, dma_chn_pkg::IDLE, '0, '0, OUT_FLAGS, pack_flags(0, 0, 0, 0));
    add_write("soft_trg", A_SOFT, 32'h1, OUT_FLAGS, pack_flags(0, 0, 1, 0));
    add_idle("soft_trg_done", 1'b0, dma_chn_pkg::IDLE, '0, '0, OUT_FLAGS, pack_flags(0, 0, 0, 0));
    add_write("soft_trg_bit0_low", A_SOFT, 32'hffff_fffe, OUT_FLAGS, pack_flags(0, 0, 0, 0));
    // invalid transfers leave every register alone.
    add_idle("sar_no_hsel", 1'b0, dma_chn_pkg::NONSEQ, A_SAR, ~r4, OUT_SAR, r4);
    add_idle("dar_htrans_idle", 1'b1, dma_chn_pkg::IDLE, A_DAR, ~rd, OUT_DAR, rd);
    add_idle("en_htrans_busy", 1'b1, dma_chn_pkg::BUSY, A_EN, 32'h1, OUT_FLAGS, '0);
    add_idle("mask_htrans_idle", 1'b1, dma_chn_pkg::IDLE, A_MASK, 32'h1f, OUT_NONE, '0);
    add_read("mask_kept", A_MASK, 32'h0f);
    add_read("clear_wo", A_CLEAR, '0);
    add_read("soft_req_wo", A_SOFT, '0);
    add_read("unmapped_above", A_EN + `DMA_ADDR_W'(4), '0);
    add_read("below_base", '0, '0);
    add_read("top_addr", '1, '0);
  endtask

  task automatic compare_outputs(input int i);
    dma_chn_pkg::data_t e;
    string              n;
    e = t_exp[i];
    n = t_name[i];
    case (t_out[i])
      OUT_SAR: check_data(n, "chn_sar", e, chn_sar);
      OUT_DAR: check_data(n, "chn_dar", e, chn_dar);
      OUT_CTRL: begin
        check_data(n, "chn_block_tl", dma_chn_pkg::data_t'(e[23:12]),
                   dma_chn_pkg::data_t'(chn_block_tl));
        check_inc(n, "chn_sinc", dma_chn_pkg::addr_inc_e'(e[7:6]), chn_sinc);
        check_inc(n, "chn_dinc", dma_chn_pkg::addr_inc_e'(e[5:4]), chn_dinc);
        check_width(n, "chn_src_width", dma_chn_pkg::tr_width_e'(e[3:2]), chn_src_width);
        check_width(n, "chn_dst_width", dma_chn_pkg::tr_width_e'(e[1:0]), chn_dst_width);
      end
      OUT_TRG: check_data(n, "chn_trg_mode", dma_chn_pkg::data_t'(e[2:1]),
                          dma_chn_pkg::data_t'(chn_trg_mode));
      OUT_FLAGS: begin
        check_bit(n, "chn_en", e[0], chn_en);
        check_bit(n, "chn_soft_trg", e[1], chn_soft_trg);
        check_bit(n, "chn_pend", e[2], chn_pend);
        check_bit(n, "chn_irq", e[3], chn_irq);
      end
      default: ;
    endcase
  endtask

  // starts on a falling edge; address phase, data phase, then the output check.
  task automatic apply_entry(input int i);
    if (t_kind[i] == K_EVENT) begin
      {en_clr, ev_pend, ev_trgcmp, ev_htfr, ev_tfr, ev_err} = t_data[i][5:0];
    end else begin
      hsel   = t_hsel[i];
      htrans = t_trans[i];
      hwrite = (t_kind[i] != K_READ);
      haddr  = t_addr[i];
    end
    @(negedge hclk);
    if (t_kind[i] == K_READ) begin
      check_data(t_name[i], "hrdata", t_exp[i], hrdata);
    end
    hsel   = 1'b0;
    htrans = dma_chn_pkg::IDLE;
    hwrite = 1'b0;
    hwdata = t_data[i];
    {en_clr, ev_pend, ev_trgcmp, ev_htfr, ev_tfr, ev_err} = '0;
    @(negedge hclk);
    compare_outputs(i);
  endtask

  initial begin : watchdog
    wait (table_ready);
    #((t_name.size() * 8 + 16) * 10);
    $display("watchdog expired before the stimulus table was done");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  initial begin : main
    hrst_n      = 1'b0;
    hsel        = 1'b0;
    htrans      = dma_chn_pkg::IDLE;
    hwrite      = 1'b0;
    haddr       = '0;
    hwdata      = '0;
    ev_err      = 1'b0;
    ev_htfr     = 1'b0;
    ev_tfr      = 1'b0;
    ev_trgcmp   = 1'b0;
    ev_pend     = 1'b0;
    en_clr      = 1'b0;
    table_ready = 1'b0;
    void'($urandom(91));
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge hclk);
    @(negedge hclk);
    hrst_n = 1'b1;
    for (int i = 0; i < t_name.size(); i++) begin
      apply_entry(i);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/dma_chn_ahb_slv.sv
// ####################
// AHB-lite slave port of the channel registers. Decodes the address phase
// into a registered select and write strobe, applies the config lock and
// returns the read data in the data phase. Always zero wait states.
// ####################
`timescale 1ns/1ps
`default_nettype none

`include "dma_chn_config.svh"

module dma_chn_ahb_slv (
  input  logic                       hclk,
  input  logic                       hrst_n,
  input  logic                       hsel,
  input  dma_chn_pkg::htrans_e       htrans,
  input  logic                       hwrite,
  input  logic [`DMA_ADDR_W-1:0]     haddr,
  input  logic                       chn_en,
  input  dma_chn_pkg::data_t         sar_img,
  input  dma_chn_pkg::data_t         dar_img,
  input  dma_chn_pkg::data_t         ctrl_a_img,
  input  dma_chn_pkg::data_t         ctrl_b_img,
  input  dma_chn_pkg::data_t         mask_img,
  input  dma_chn_pkg::data_t         status_img,
  input  dma_chn_pkg::data_t         en_img,
  output dma_chn_pkg::reg_sel_e      sel,
  output logic                       wr_stb,
  output dma_chn_pkg::data_t         hrdata
);

  logic                      valid;
  logic [`DMA_ADDR_W-1:0]    ofs;
  dma_chn_pkg::reg_sel_e     sel_nxt;
  logic                      cfg_locked;
  logic                      rd_q;

  assign valid = hsel && (htrans == dma_chn_pkg::NONSEQ || htrans == dma_chn_pkg::SEQ);
  assign ofs   = haddr - `DMA_ADDR_W'(`DMA_CHN_BASE); // wraps out of range below the base.

  always_comb begin
    sel_nxt = dma_chn_pkg::SEL_NONE;
    if (valid) begin
      case (ofs)
        `DMA_ADDR_W'(`DMA_SAR_OFS):        sel_nxt = dma_chn_pkg::SEL_SAR;
        `DMA_ADDR_W'(`DMA_DAR_OFS):        sel_nxt = dma_chn_pkg::SEL_DAR;
        `DMA_ADDR_W'(`DMA_CTRL_A_OFS):     sel_nxt = dma_chn_pkg::SEL_CTRL_A;
        `DMA_ADDR_W'(`DMA_CTRL_B_OFS):     sel_nxt = dma_chn_pkg::SEL_CTRL_B;
        `DMA_ADDR_W'(`DMA_INT_MASK_OFS):   sel_nxt = dma_chn_pkg::SEL_INT_MASK;
        `DMA_ADDR_W'(`DMA_INT_STATUS_OFS): sel_nxt = dma_chn_pkg::SEL_INT_STATUS;
        `DMA_ADDR_W'(`DMA_INT_CLEAR_OFS):  sel_nxt = dma_chn_pkg::SEL_INT_CLEAR;
        `DMA_ADDR_W'(`DMA_SOFT_REQ_OFS):   sel_nxt = dma_chn_pkg::SEL_SOFT_REQ;
        `DMA_ADDR_W'(`DMA_EN_OFS):         sel_nxt = dma_chn_pkg::SEL_EN;
        default:                           sel_nxt = dma_chn_pkg::SEL_NONE;
      endcase
    end
  end

  // transfer setup cannot change under a running channel.
  assign cfg_locked = chn_en && (sel_nxt == dma_chn_pkg::SEL_SAR ||
                                 sel_nxt == dma_chn_pkg::SEL_DAR ||
                                 sel_nxt == dma_chn_pkg::SEL_CTRL_A ||
                                 sel_nxt == dma_chn_pkg::SEL_CTRL_B);

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      sel    <= dma_chn_pkg::SEL_NONE;
      wr_stb <= 1'b0;
      rd_q   <= 1'b0;
    end else begin
      sel    <= sel_nxt;
      wr_stb <= valid && hwrite && !cfg_locked;
      rd_q   <= valid && !hwrite;
    end
  end

  // clear and soft request are write only and fall into the default.
  always_comb begin
    hrdata = '0;
    if (rd_q) begin
      case (sel)
        dma_chn_pkg::SEL_SAR:        hrdata = sar_img;
        dma_chn_pkg::SEL_DAR:        hrdata = dar_img;
        dma_chn_pkg::SEL_CTRL_A:     hrdata = ctrl_a_img;
        dma_chn_pkg::SEL_CTRL_B:     hrdata = ctrl_b_img;
        dma_chn_pkg::SEL_INT_MASK:   hrdata = mask_img;
        dma_chn_pkg::SEL_INT_STATUS: hrdata = status_img;
        dma_chn_pkg::SEL_EN:         hrdata = en_img;
        default:                     hrdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/dma_chn_cfg_regs.sv
// ####################
// Channel configuration registers: addresses, control A and B, the enable
// and the software trigger pulse. Written in the data phase of the bus.
// ####################
`timescale 1ns/1ps
`default_nettype none

module dma_chn_cfg_regs (
  input  logic                        hclk,
  input  logic                        hrst_n,
  input  dma_chn_pkg::reg_sel_e       sel,
  input  logic                        wr_stb,
  input  dma_chn_pkg::data_t          hwdata,
  input  logic                        en_clr,
  output dma_chn_pkg::data_t          sar_img,
  output dma_chn_pkg::data_t          dar_img,
  output dma_chn_pkg::data_t          ctrl_a_img,
  output dma_chn_pkg::data_t          ctrl_b_img,
  output dma_chn_pkg::data_t          en_img,
  output dma_chn_pkg::data_t          chn_sar,
  output dma_chn_pkg::data_t          chn_dar,
  output dma_chn_pkg::block_tl_t      chn_block_tl,
  output dma_chn_pkg::addr_inc_e      chn_sinc,
  output dma_chn_pkg::addr_inc_e      chn_dinc,
  output dma_chn_pkg::tr_width_e      chn_src_width,
  output dma_chn_pkg::tr_width_e      chn_dst_width,
  output logic [1:0]                  chn_trg_mode,
  output logic                        int_en,
  output logic                        chn_en,
  output logic                        chn_soft_trg
);

  logic wr_sar;
  logic wr_dar;
  logic wr_ctrl_a;
  logic wr_ctrl_b;
  logic wr_soft_req;
  logic wr_en;

  assign wr_sar      = wr_stb && (sel == dma_chn_pkg::SEL_SAR);
  assign wr_dar      = wr_stb && (sel == dma_chn_pkg::SEL_DAR);
  assign wr_ctrl_a   = wr_stb && (sel == dma_chn_pkg::SEL_CTRL_A);
  assign wr_ctrl_b   = wr_stb && (sel == dma_chn_pkg::SEL_CTRL_B);
  assign wr_soft_req = wr_stb && (sel == dma_chn_pkg::SEL_SOFT_REQ);
  assign wr_en       = wr_stb && (sel == dma_chn_pkg::SEL_EN);

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      chn_sar <= '0;
      chn_dar <= '0;
    end else begin
      if (wr_sar) begin
        chn_sar <= hwdata;
      end
      if (wr_dar) begin
        chn_dar <= hwdata;
      end
    end
  end

  // control A. block length and the per-side increment and width.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      chn_block_tl  <= '0;
      chn_sinc      <= dma_chn_pkg::ADDR_INC;
      chn_dinc      <= dma_chn_pkg::ADDR_INC;
      chn_src_width <= dma_chn_pkg::TR_BYTE;
      chn_dst_width <= dma_chn_pkg::TR_BYTE;
    end else if (wr_ctrl_a) begin
      chn_block_tl  <= hwdata[23:12];
      chn_sinc      <= dma_chn_pkg::addr_inc_e'(hwdata[7:6]);
      chn_dinc      <= dma_chn_pkg::addr_inc_e'(hwdata[5:4]);
      chn_src_width <= dma_chn_pkg::tr_width_e'(hwdata[3:2]);
      chn_dst_width <= dma_chn_pkg::tr_width_e'(hwdata[1:0]);
    end
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      chn_trg_mode <= 2'b00;
      int_en       <= 1'b0;
    end else if (wr_ctrl_b) begin
      chn_trg_mode <= hwdata[2:1];
      int_en       <= hwdata[0];
    end
  end

  // bus write has priority over the state machine clear.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      chn_en <= 1'b0;
    end else if (wr_en) begin
      chn_en <= hwdata[0];
    end else if (en_clr) begin
      chn_en <= 1'b0;
    end
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      chn_soft_trg <= 1'b0;
    end else begin
      chn_soft_trg <= wr_soft_req && hwdata[0]; // single cycle pulse.
    end
  end

  assign sar_img    = chn_sar;
  assign dar_img    = chn_dar;
  assign ctrl_a_img = dma_chn_pkg::data_t'({chn_block_tl, 4'h0, chn_sinc, chn_dinc,
                                            chn_src_width, chn_dst_width});
  assign ctrl_b_img = dma_chn_pkg::data_t'({chn_trg_mode, int_en});
  assign en_img     = dma_chn_pkg::data_t'(chn_en);

endmodule

`default_nettype wire

// File: hdl/dma_chn_config.svh
// ####################
// Bus and register layout constants of the DMA channel register block.
// Included by the package and by the blocks that decode the address.
// ####################
`ifndef DMA_CHN_CONFIG_SVH
`define DMA_CHN_CONFIG_SVH

`define DMA_ADDR_W         10
`define DMA_DATA_W         32
`define DMA_CHN_BASE       'h60
`define DMA_BLOCK_TL_W     12
`define DMA_INT_W          5

// register offsets from the channel base.
`define DMA_SAR_OFS        'h00
`define DMA_DAR_OFS        'h04
`define DMA_CTRL_A_OFS     'h08
`define DMA_CTRL_B_OFS     'h0C
`define DMA_INT_MASK_OFS   'h10
`define DMA_INT_STATUS_OFS 'h14
`define DMA_INT_CLEAR_OFS  'h18
`define DMA_SOFT_REQ_OFS   'h1C
`define DMA_EN_OFS         'h20

`endif

// File: hdl/dma_chn_int_ctrl.sv
// ####################
// Channel interrupt block. Five set-dominant status bits, their mask,
// write-one-to-clear and the masked channel interrupt.
// ####################
`timescale 1ns/1ps
`default_nettype none

module dma_chn_int_ctrl (
  input  logic                   hclk,
  input  logic                   hrst_n,
  input  dma_chn_pkg::reg_sel_e  sel,
  input  logic                   wr_stb,
  input  dma_chn_pkg::data_t     hwdata,
  input  logic                   int_en,
  input  logic                   ev_err,
  input  logic                   ev_htfr,
  input  logic                   ev_tfr,
  input  logic                   ev_trgcmp,
  input  logic                   ev_pend,
  output dma_chn_pkg::data_t     mask_img,
  output dma_chn_pkg::data_t     status_img,
  output logic                   chn_pend,
  output logic                   chn_irq
);

  dma_chn_pkg::int_vec_t ev_vec;
  dma_chn_pkg::int_vec_t mask;
  dma_chn_pkg::int_vec_t status;
  dma_chn_pkg::int_vec_t clr_q;
  logic                  wr_mask;
  logic                  wr_clear;

  assign ev_vec   = {ev_pend, ev_trgcmp, ev_htfr, ev_tfr, ev_err};
  assign wr_mask  = wr_stb && (sel == dma_chn_pkg::SEL_INT_MASK);
  assign wr_clear = wr_stb && (sel == dma_chn_pkg::SEL_INT_CLEAR);

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      mask <= '0;
    end else if (wr_mask) begin
      mask <= dma_chn_pkg::int_vec_t'(hwdata);
    end
  end

  // clear bits live for one cycle after the write.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      clr_q <= '0;
    end else begin
      clr_q <= wr_clear ? dma_chn_pkg::int_vec_t'(hwdata) : '0;
    end
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      status <= '0;
    end else begin
      status <= ev_vec | (status & ~clr_q); // an event beats a clear.
    end
  end

  assign mask_img   = dma_chn_pkg::data_t'(mask);
  // pend is kept off the status image.
  assign status_img = dma_chn_pkg::data_t'(status[3:0]);
  assign chn_pend   = status[4];
  assign chn_irq    = int_en && (|(status & mask));

endmodule

`default_nettype wire

// File: hdl/dma_chn_pkg.sv
// ####################
// Types shared by the DMA channel registers and their testbench.
// Referenced by scoped name, never imported.
// ####################
`default_nettype none

`include "dma_chn_config.svh"

package dma_chn_pkg;

  // AHB transfer type.
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // register addressed by an access.
  typedef enum logic [3:0] {
    SEL_NONE       = 4'd0,
    SEL_SAR        = 4'd1,
    SEL_DAR        = 4'd2,
    SEL_CTRL_A     = 4'd3,
    SEL_CTRL_B     = 4'd4,
    SEL_INT_MASK   = 4'd5,
    SEL_INT_STATUS = 4'd6,
    SEL_INT_CLEAR  = 4'd7,
    SEL_SOFT_REQ   = 4'd8,
    SEL_EN         = 4'd9
  } reg_sel_e;

  typedef enum logic [1:0] {
    ADDR_INC   = 2'b00,
    ADDR_DEC   = 2'b01,
    ADDR_FIXED = 2'b10
  } addr_inc_e;

  typedef enum logic [1:0] {
    TR_BYTE = 2'b00,
    TR_HALF = 2'b01,
    TR_WORD = 2'b10
  } tr_width_e;

  typedef logic [`DMA_DATA_W-1:0]     data_t;
  typedef logic [`DMA_BLOCK_TL_W-1:0] block_tl_t;
  typedef logic [`DMA_INT_W-1:0]      int_vec_t; // 4 pend, 3 trgcmp, 2 htfr, 1 tfr, 0 err.

endpackage

`default_nettype wire

// File: hdl/dma_chn_regs.sv
// ####################
// Register block of one DMA channel. Joins the AHB-lite slave port to the
// configuration and interrupt registers seen by the channel FSM.
// ####################
`timescale 1ns/1ps
`default_nettype none

`include "dma_chn_config.svh"

module dma_chn_regs (
  input  logic                       hclk,
  input  logic                       hrst_n,
  // AHB-lite slave.
  input  logic                       hsel,
  input  dma_chn_pkg::htrans_e       htrans,
  input  logic                       hwrite,
  input  logic [`DMA_ADDR_W-1:0]     haddr,
  input  dma_chn_pkg::data_t         hwdata,
  output dma_chn_pkg::data_t         hrdata,
  // channel FSM side.
  input  logic                       ev_err,
  input  logic                       ev_htfr,
  input  logic                       ev_tfr,
  input  logic                       ev_trgcmp,
  input  logic                       ev_pend,
  input  logic                       en_clr,
  output dma_chn_pkg::data_t         chn_sar,
  output dma_chn_pkg::data_t         chn_dar,
  output dma_chn_pkg::block_tl_t     chn_block_tl,
  output dma_chn_pkg::addr_inc_e     chn_sinc,
  output dma_chn_pkg::addr_inc_e     chn_dinc,
  output dma_chn_pkg::tr_width_e     chn_src_width,
  output dma_chn_pkg::tr_width_e     chn_dst_width,
  output logic [1:0]                 chn_trg_mode,
  output logic                       chn_en,
  output logic                       chn_soft_trg,
  output logic                       chn_pend,
  output logic                       chn_irq
);

  dma_chn_pkg::reg_sel_e sel;
  logic                  wr_stb;
  logic                  int_en;
  dma_chn_pkg::data_t    sar_img;
  dma_chn_pkg::data_t    dar_img;
  dma_chn_pkg::data_t    ctrl_a_img;
  dma_chn_pkg::data_t    ctrl_b_img;
  dma_chn_pkg::data_t    en_img;
  dma_chn_pkg::data_t    mask_img;
  dma_chn_pkg::data_t    status_img;

  dma_chn_ahb_slv u_slv (
    .hclk       (hclk),
    .hrst_n     (hrst_n),
    .hsel       (hsel),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .haddr      (haddr),
    .chn_en     (chn_en),
    .sar_img    (sar_img),
    .dar_img    (dar_img),
    .ctrl_a_img (ctrl_a_img),
    .ctrl_b_img (ctrl_b_img),
    .mask_img   (mask_img),
    .status_img (status_img),
    .en_img     (en_img),
    .sel        (sel),
    .wr_stb     (wr_stb),
    .hrdata     (hrdata)
  );

  dma_chn_cfg_regs u_cfg (
    .hclk          (hclk),
    .hrst_n        (hrst_n),
    .sel           (sel),
    .wr_stb        (wr_stb),
    .hwdata        (hwdata),
    .en_clr        (en_clr),
    .sar_img       (sar_img),
    .dar_img       (dar_img),
    .ctrl_a_img    (ctrl_a_img),
    .ctrl_b_img    (ctrl_b_img),
    .en_img        (en_img),
    .chn_sar       (chn_sar),
    .chn_dar       (chn_dar),
    .chn_block_tl  (chn_block_tl),
    .chn_sinc      (chn_sinc),
    .chn_dinc      (chn_dinc),
    .chn_src_width (chn_src_width),
    .chn_dst_width (chn_dst_width),
    .chn_trg_mode  (chn_trg_mode),
    .int_en        (int_en),
    .chn_en        (chn_en),
    .chn_soft_trg  (chn_soft_trg)
  );

  dma_chn_int_ctrl u_int (
    .hclk       (hclk),
    .hrst_n     (hrst_n),
    .sel        (sel),
    .wr_stb     (wr_stb),
    .hwdata     (hwdata),
    .int_en     (int_en),
    .ev_err     (ev_err),
    .ev_htfr    (ev_htfr),
    .ev_tfr     (ev_tfr),
    .ev_trgcmp  (ev_trgcmp),
    .ev_pend    (ev_pend),
    .mask_img   (mask_img),
    .status_img (status_img),
    .chn_pend   (chn_pend),
    .chn_irq    (chn_irq)
  );

endmodule

`default_nettype wire
